// File: design/link_cfg.svh
`ifndef LINK_CFG_SVH
`define LINK_CFG_SVH

// ****************************************
// link geometry
// ****************************************

// bits carried by one lane in one cycle
`define LINK_CHANNEL_WIDTH 8

// physical lanes between the two chips
`define LINK_NUM_CHANNELS 4

// beats per ring packet, so 64 bits per packet
`define LINK_RING_BYTES 8

// ****************************************
// calibration and flow control
// ****************************************

// cycles of training pattern sent after reset
`define LINK_CALIB_CYCLES 16

// training word, sent alternately true and inverted
`define LINK_CALIB_PATTERN 8'hA5

// rx buffer depth in packets, also the tx credit count at start
`define LINK_TOKEN_CREDITS 4

`endif

// File: design/link_data_pkg.sv
`include "link_cfg.svh"

// datapath types shared by tx, rx and the top level
package link_data_pkg;

   // one lane beat
   typedef logic [`LINK_CHANNEL_WIDTH-1:0] beat_t;

   // a whole ring packet, beat 0 in the low bits
   typedef logic [`LINK_CHANNEL_WIDTH*`LINK_RING_BYTES-1:0] packet_t;

   // one bit per physical lane
   typedef logic [`LINK_NUM_CHANNELS-1:0] lane_mask_t;

   // position of a beat inside its packet
   typedef logic [$clog2(`LINK_RING_BYTES)-1:0] beat_idx_t;

   // credits held by tx, or packets held by rx
   typedef logic [$clog2(`LINK_TOKEN_CREDITS+1)-1:0] credit_t;

   // everything that crosses the board on the data wires
   typedef struct packed {
      lane_mask_t                         valid;
      beat_t [`LINK_NUM_CHANNELS-1:0]     data;
   } lane_bus_t;

endpackage

// File: design/link_ctrl_pkg.sv
// control side types, state machine and the control bundle

package link_ctrl_pkg;

   import link_data_pkg::*;

   // link bring-up sequence
   typedef enum logic [2:0] {
      LS_RESET,
      LS_CALIB,
      LS_DECIDE,
      LS_ACTIVE,
      LS_DEAD
   } link_state_t;

   // sent from link_ctrl to both datapaths
   typedef struct packed {
      // training pattern phase in progress
      logic       calib;
      // link is up, packets may flow
      logic       active;
      // lanes that passed training
      lane_mask_t active_mask;
   } link_ctl_t;

endpackage

// File: design/link_ctrl.sv
`timescale 1ns/1ps
`include "link_cfg.svh"

module link_ctrl
   import link_data_pkg::*;
   import link_ctrl_pkg::*;
(
   input  logic       io_master_clk,
   input  logic       reset_i,
   input  lane_mask_t lane_good_i,
   input  logic       calib_done_i,
   output link_ctl_t  ctl_o,
   output logic       link_up_o,
   output logic       link_dead_o,
   output lane_mask_t active_mask_o
);

   localparam int cal_width_lp = $clog2(`LINK_CALIB_CYCLES);

   link_state_t             state_r;
   link_state_t             state_n;
   logic [cal_width_lp-1:0] cal_cnt_r;
   lane_mask_t              mask_r;
   logic                    cal_last;
   logic                    verdict;

   // ****************************************
   // state machine
   // ****************************************

   // last cycle of the training window
   assign cal_last = (cal_cnt_r == cal_width_lp'(`LINK_CALIB_CYCLES - 1));

   // receiver has finished checking and its lane mask is final
   assign verdict = (state_r == LS_DECIDE) && calib_done_i;

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         // one idle cycle so both datapaths see a clean start
         LS_RESET:
            state_n = LS_CALIB;
         LS_CALIB:
            if (cal_last)
               state_n = LS_DECIDE;
         // hold here until rx drains the pattern through its pipeline
         LS_DECIDE:
            if (calib_done_i)
               state_n = (lane_good_i != '0) ? LS_ACTIVE : LS_DEAD;
         // both end states are left only by reset
         LS_ACTIVE:
            state_n = LS_ACTIVE;
         LS_DEAD:
            state_n = LS_DEAD;
         default:
            state_n = LS_RESET;
      endcase
   end

   always_ff @(posedge io_master_clk)
   begin
      if (reset_i)
      begin
         state_r   <= LS_RESET;
         cal_cnt_r <= '0;
         mask_r    <= '0;
      end
      else
      begin
         state_r <= state_n;
         // count training cycles and clear outside the window
         if (state_r == LS_CALIB)
            cal_cnt_r <= cal_cnt_r + 1'b1;
         else
            cal_cnt_r <= '0;
         // latch the lane verdict once
         if (verdict)
            mask_r <= lane_good_i;
      end
   end

   // ****************************************
   // outputs
   // ****************************************

   assign ctl_o.calib       = (state_r == LS_CALIB);
   assign ctl_o.active      = (state_r == LS_ACTIVE);
   assign ctl_o.active_mask = mask_r;

   assign link_up_o     = (state_r == LS_ACTIVE);
   assign link_dead_o   = (state_r == LS_DEAD);
   assign active_mask_o = mask_r;

   // ****************************************
   // checks
   // ****************************************

   // tx and rx slice by this mask so a change mid-stream would scramble packets
   mask_stable_a : assert property (@(posedge io_master_clk) disable iff (reset_i)
      link_up_o |=> $stable(active_mask_o));

   // a link is never reported up and dead at once
   up_dead_a : assert property (@(posedge io_master_clk) disable iff (reset_i)
      !(link_up_o && link_dead_o));

endmodule

// File: design/link_tx_packer.sv
`timescale 1ns/1ps
`include "link_cfg.svh"

module link_tx_packer
   import link_data_pkg::*;
   import link_ctrl_pkg::*;
(
   input  logic      io_master_clk,
   input  logic      reset_i,
   input  link_ctl_t ctl_i,
   input  logic      core_v_i,
   input  packet_t   core_data_i,
   output logic      core_yumi_o,
   output lane_bus_t tline_o,
   input  logic      tline_token_i
);

   // wide enough to hold one past the last beat
   localparam int pos_width_lp = $clog2(`LINK_RING_BYTES) + 1;

   logic                    busy_r;
   packet_t                 pkt_r;
   beat_idx_t               beat_idx_r;
   credit_t                 credit_r;
   logic                    cal_on_r;
   logic                    cal_phase_r;
   lane_bus_t               beat_bus;
   logic [pos_width_lp-1:0] beat_end;

   // take a packet only when idle, up, and rx has room for it
   assign core_yumi_o = ctl_i.active & ~busy_r & (credit_r != '0) & core_v_i;

   // ****************************************
   // lane slicing
   // ****************************************

   // active lanes in increasing index each take the next beat
   always_comb
   begin
      logic [pos_width_lp-1:0] pos;
      pos      = {1'b0, beat_idx_r};
      beat_bus = '0;
      for (int l = 0; l < `LINK_NUM_CHANNELS; l++)
      begin
         if (ctl_i.active_mask[l] && (pos < `LINK_RING_BYTES))
         begin
            beat_bus.valid[l] = 1'b1;
            beat_bus.data[l]  = pkt_r[pos*`LINK_CHANNEL_WIDTH +: `LINK_CHANNEL_WIDTH];
            pos = pos + 1'b1;
         end
      end
      // first beat for the next cycle
      beat_end = pos;
   end

   // packet beats when busy, else training pattern, else idle wires
   always_comb
   begin
      tline_o = '0;
      if (busy_r)
         tline_o = beat_bus;
      else if (cal_on_r)
      begin
         tline_o.valid = '1;
         for (int l = 0; l < `LINK_NUM_CHANNELS; l++)
            tline_o.data[l] = cal_phase_r ? ~beat_t'(`LINK_CALIB_PATTERN)
                                          : beat_t'(`LINK_CALIB_PATTERN);
      end
   end

   // ****************************************
   // control registers
   // ****************************************

   always_ff @(posedge io_master_clk)
   begin
      if (reset_i)
      begin
         busy_r      <= 1'b0;
         beat_idx_r  <= '0;
         credit_r    <= credit_t'(`LINK_TOKEN_CREDITS);
         cal_on_r    <= 1'b0;
         cal_phase_r <= 1'b0;
      end
      else
      begin
         // pattern trails the calib flag by one cycle, true word first
         cal_on_r <= ctl_i.calib;
         if (cal_on_r)
            cal_phase_r <= ~cal_phase_r;
         else
            cal_phase_r <= 1'b0;

         if (core_yumi_o)
         begin
            busy_r     <= 1'b1;
            beat_idx_r <= '0;
         end
         else if (busy_r)
         begin
            // last slice of the packet goes out this cycle
            if (beat_end >= `LINK_RING_BYTES)
               busy_r <= 1'b0;
            beat_idx_r <= beat_idx_t'(beat_end);
         end

         // one credit spent per packet, one back per token
         credit_r <= credit_r - credit_t'(core_yumi_o) + credit_t'(tline_token_i);
      end
   end

   // packet payload
   always_ff @(posedge io_master_clk)
   begin
      if (core_yumi_o)
         pkt_r <= core_data_i;
   end

   // rx never returns more tokens than packets it was sent
   credit_bound_a : assert property (@(posedge io_master_clk) disable iff (reset_i)
      credit_r <= credit_t'(`LINK_TOKEN_CREDITS));

endmodule

// File: design/link_rx_assembler.sv
`timescale 1ns/1ps
`include "link_cfg.svh"

module link_rx_assembler
   import link_data_pkg::*;
   import link_ctrl_pkg::*;
(
   input  logic       io_master_clk,
   input  logic       reset_i,
   input  link_ctl_t  ctl_i,
   input  lane_bus_t  tline_i,
   output logic       tline_token_o,
   output lane_mask_t lane_good_o,
   output logic       calib_done_o,
   output logic       core_v_o,
   output packet_t    core_data_o,
   input  logic       core_ready_i
);

   localparam int pos_width_lp = $clog2(`LINK_RING_BYTES) + 1;
   localparam int cal_width_lp = $clog2(`LINK_CALIB_CYCLES);
   localparam int depth_lp     = `LINK_TOKEN_CREDITS;
   localparam int ptr_width_lp = $clog2(depth_lp);

   lane_bus_t               line_r;
   logic                    calib_d1_r;
   logic                    calib_d2_r;
   logic [cal_width_lp-1:0] cal_cnt_r;
   logic                    cal_phase_r;
   lane_mask_t              lane_good_r;
   logic                    calib_done_r;
   beat_t                   expect_beat;
   lane_mask_t              lane_ok;
   packet_t                 asm_pkt_r;
   packet_t                 asm_next;
   beat_idx_t               asm_idx_r;
   logic [pos_width_lp-1:0] asm_end;
   logic                    wr_en;
   logic                    rd_en;
   packet_t                 fifo_mem [depth_lp];
   logic [ptr_width_lp-1:0] wr_ptr_r;
   logic [ptr_width_lp-1:0] rd_ptr_r;
   credit_t                 count_r;
   logic                    token_r;

   // ****************************************
   // line capture and calibration check
   // ****************************************

   // pattern expected in the current checked cycle
   assign expect_beat = cal_phase_r ? ~beat_t'(`LINK_CALIB_PATTERN)
                                    : beat_t'(`LINK_CALIB_PATTERN);

   always_comb
   begin
      for (int l = 0; l < `LINK_NUM_CHANNELS; l++)
         lane_ok[l] = line_r.valid[l] && (line_r.data[l] == expect_beat);
   end

   always_ff @(posedge io_master_clk)
   begin
      if (reset_i)
      begin
         line_r       <= '0;
         calib_d1_r   <= 1'b0;
         calib_d2_r   <= 1'b0;
         cal_cnt_r    <= '0;
         cal_phase_r  <= 1'b0;
         lane_good_r  <= '1;
         calib_done_r <= 1'b0;
      end
      else
      begin
         line_r <= tline_i;
         // tx register plus our line register put the pattern two cycles late
         calib_d1_r <= ctl_i.calib;
         calib_d2_r <= calib_d1_r;
         if (calib_d2_r && !calib_done_r)
         begin
            // one bad cycle condemns the lane
            lane_good_r <= lane_good_r & lane_ok;
            cal_phase_r <= ~cal_phase_r;
            cal_cnt_r   <= cal_cnt_r + 1'b1;
            if (cal_cnt_r == cal_width_lp'(`LINK_CALIB_CYCLES - 1))
               calib_done_r <= 1'b1;
         end
      end
   end

   assign lane_good_o  = lane_good_r;
   assign calib_done_o = calib_done_r;

   // ****************************************
   // packet reassembly
   // ****************************************

   // same lane rule as tx, counting only valid beats on active lanes
   always_comb
   begin
      logic [pos_width_lp-1:0] pos;
      pos      = {1'b0, asm_idx_r};
      asm_next = asm_pkt_r;
      for (int l = 0; l < `LINK_NUM_CHANNELS; l++)
      begin
         if (ctl_i.active && ctl_i.active_mask[l] && line_r.valid[l]
             && (pos < `LINK_RING_BYTES))
         begin
            asm_next[pos*`LINK_CHANNEL_WIDTH +: `LINK_CHANNEL_WIDTH] = line_r.data[l];
            pos = pos + 1'b1;
         end
      end
      asm_end = pos;
   end

   // packet complete this cycle
   assign wr_en = (asm_end >= `LINK_RING_BYTES);

   always_ff @(posedge io_master_clk)
   begin
      if (reset_i)
         asm_idx_r <= '0;
      else if (wr_en)
         asm_idx_r <= '0;
      else
         asm_idx_r <= beat_idx_t'(asm_end);
   end

   always_ff @(posedge io_master_clk)
   begin
      asm_pkt_r <= asm_next;
      if (wr_en)
         fifo_mem[wr_ptr_r] <= asm_next;
   end

   // ****************************************
   // receive buffer and token return
   // ****************************************

   assign core_v_o    = (count_r != '0);
   assign core_data_o = fifo_mem[rd_ptr_r];
   assign rd_en       = core_v_o & core_ready_i;

   always_ff @(posedge io_master_clk)
   begin
      if (reset_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
         token_r  <= 1'b0;
      end
      else
      begin
         if (wr_en)
            wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(depth_lp - 1)) ? '0 : wr_ptr_r + 1'b1;
         if (rd_en)
            rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(depth_lp - 1)) ? '0 : rd_ptr_r + 1'b1;
         count_r <= count_r + credit_t'(wr_en) - credit_t'(rd_en);
         // each pop frees a slot, tell tx
         token_r <= rd_en;
      end
   end

   assign tline_token_o = token_r;

   // tx credits must keep the sender from overrunning the buffer
   no_overflow_a : assert property (@(posedge io_master_clk) disable iff (reset_i)
      wr_en |-> (count_r != credit_t'(depth_lp)));

endmodule

// File: design/comm_link_top.sv
`timescale 1ns/1ps

module comm_link_top
   import link_data_pkg::*;
   import link_ctrl_pkg::*;
(
   input  logic       io_master_clk,
   input  logic       reset_i,

   // packets in from the core, valid/yumi
   input  logic       core_v_i,
   input  packet_t    core_data_i,
   output logic       core_yumi_o,

   // packets out to the core, valid/ready
   output logic       core_v_o,
   output packet_t    core_data_o,
   input  logic       core_ready_i,

   // board wires
   output lane_bus_t  tline_o,
   output logic       tline_token_o,
   input  lane_bus_t  tline_i,
   input  logic       tline_token_i,

   // link status
   output logic       link_up_o,
   output logic       link_dead_o,
   output lane_mask_t active_mask_o
);

   link_ctl_t  ctl;
   lane_mask_t lane_good;
   logic       calib_done;

   // ****************************************
   // bring-up control
   // ****************************************

   link_ctrl u_ctrl (
      .io_master_clk (io_master_clk),
      .reset_i       (reset_i),
      .lane_good_i   (lane_good),
      .calib_done_i  (calib_done),
      .ctl_o         (ctl),
      .link_up_o     (link_up_o),
      .link_dead_o   (link_dead_o),
      .active_mask_o (active_mask_o)
   );

   // ****************************************
   // datapaths
   // ****************************************

   // outbound side, credits come back on tline_token_i
   link_tx_packer u_tx (
      .io_master_clk (io_master_clk),
      .reset_i       (reset_i),
      .ctl_i         (ctl),
      .core_v_i      (core_v_i),
      .core_data_i   (core_data_i),
      .core_yumi_o   (core_yumi_o),
      .tline_o       (tline_o),
      .tline_token_i (tline_token_i)
   );

   // inbound side, also judges the lanes during training
   link_rx_assembler u_rx (
      .io_master_clk (io_master_clk),
      .reset_i       (reset_i),
      .ctl_i         (ctl),
      .tline_i       (tline_i),
      .tline_token_o (tline_token_o),
      .lane_good_o   (lane_good),
      .calib_done_o  (calib_done),
      .core_v_o      (core_v_o),
      .core_data_o   (core_data_o),
      .core_ready_i  (core_ready_i)
   );

endmodule

// File: sim/tb_comm_link.sv
`timescale 1ns/1ps
`include "link_cfg.svh"

module tb_comm_link
   import link_data_pkg::*;
();

   localparam int golden_depth_lp = 64;
   localparam int reset_cycles_lp = 16;
   localparam int dead_watch_lp   = 32;

   logic       io_master_clk;
   logic       reset_i;
   logic       core_v_i;
   packet_t    core_data_i;
   logic       core_yumi_o;
   logic       core_v_o;
   packet_t    core_data_o;
   logic       core_ready_i;
   lane_bus_t  tline_o;
   logic       tline_token_o;
   lane_bus_t  tline_i;
   logic       tline_token_i;
   logic       link_up_o;
   logic       link_dead_o;
   lane_mask_t active_mask_o;

   // lanes whose top data bit is stuck high on the board
   lane_mask_t fault_mask;
   packet_t    golden_mem [golden_depth_lp];
   packet_t    expect_q [$];
   string      test_name;
   int         seed = 32'hf905_9e1e;
   int         error_cnt = 0;
   int         accepted_cnt = 0;
   int         delivered_cnt = 0;
   int         cycle_cnt = 0;
   int         cycle_limit = 0;

   comm_link_top DUT (
      .io_master_clk (io_master_clk),
      .reset_i       (reset_i),
      .core_v_i      (core_v_i),
      .core_data_i   (core_data_i),
      .core_yumi_o   (core_yumi_o),
      .core_v_o      (core_v_o),
      .core_data_o   (core_data_o),
      .core_ready_i  (core_ready_i),
      .tline_o       (tline_o),
      .tline_token_o (tline_token_o),
      .tline_i       (tline_i),
      .tline_token_i (tline_token_i),
      .link_up_o     (link_up_o),
      .link_dead_o   (link_dead_o),
      .active_mask_o (active_mask_o)
   );

   // ****************************************
   // clock, loopback and watchdog
   // ****************************************

   initial
   begin
      io_master_clk = 1'b0;
      forever #2 io_master_clk = ~io_master_clk;
   end

   // wires looped back with bit 7 stuck high on faulted lanes
   always_comb
   begin
      tline_i = tline_o;
      for (int l = 0; l < `LINK_NUM_CHANNELS; l++)
         if (fault_mask[l])
            tline_i.data[l][`LINK_CHANNEL_WIDTH-1] = 1'b1;
   end

   assign tline_token_i = tline_token_o;

   initial
   begin
      wait (cycle_limit > 0);
      forever
      begin
         @(posedge io_master_clk);
         cycle_cnt++;
         if (cycle_cnt > cycle_limit)
         begin
            $display("timeout after %0d cycles, the link stopped making progress", cycle_cnt);
            $display("=== FAIL ===");
            $finish;
         end
      end
   end

   // sender may run ahead of the core only by the rx buffer depth
   initial
   begin
      forever
      begin
         @(posedge io_master_clk);
         assert (accepted_cnt - delivered_cnt <= `LINK_TOKEN_CREDITS)
         else
         begin
            $display("Error in %s: %0d packets in flight, more than the credit count",
                     test_name, accepted_cnt - delivered_cnt);
            error_cnt++;
         end
      end
   end

   // ****************************************
   // checks and stimulus tasks
   // ****************************************

   task automatic check_value(input string what, input logic [63:0] exp_val,
                              input logic [63:0] act_val);
      assert (act_val === exp_val)
      else
      begin
         $display("Fail %s: %s expected %h actual %h", test_name, what, exp_val, act_val);
         error_cnt++;
      end
   endtask

   task automatic check_true(input string what, input logic cond);
      assert (cond === 1'b1)
      else
      begin
         $display("Error in %s: %s", test_name, what);
         error_cnt++;
      end
   endtask

   function automatic string kind_name(input int kind);
      case (kind)
         0:       return "ready_high";
         1:       return "ready_random";
         2:       return "dead_link";
         default: return "unknown";
      endcase
   endfunction

   // 16 cycles of reset with the given wire faults and idle outputs checked before release
   task automatic apply_reset(input lane_mask_t fault);
      @(negedge io_master_clk);
      accepted_cnt  = 0;
      delivered_cnt = 0;
      expect_q.delete();
      @(posedge io_master_clk);
      fault_mask   <= fault;
      reset_i      <= 1'b1;
      core_v_i     <= 1'b0;
      core_data_i  <= '0;
      core_ready_i <= 1'b0;
      repeat (reset_cycles_lp - 1) @(posedge io_master_clk);
      @(negedge io_master_clk);
      check_true("outputs not idle during reset",
                 !link_up_o && !link_dead_o && !core_yumi_o && !core_v_o
                 && (tline_o.valid == '0) && !tline_token_o);
      @(posedge io_master_clk);
      reset_i <= 1'b0;
   endtask

   // training ends in either up or dead
   task automatic wait_link();
      @(negedge io_master_clk);
      while (!(link_up_o || link_dead_o))
         @(negedge io_master_clk);
   endtask

   // offer packets in order and record each one the DUT takes
   task automatic send_packets(input int base, input int count);
      for (int i = 0; i < count; i++)
      begin
         @(posedge io_master_clk);
         core_v_i    <= 1'b1;
         core_data_i <= golden_mem[base + i];
         @(negedge io_master_clk);
         while (!core_yumi_o)
            @(negedge io_master_clk);
         expect_q.push_back(golden_mem[base + i]);
         accepted_cnt++;
      end
      // taken on this edge
      @(posedge io_master_clk);
      core_v_i <= 1'b0;
   endtask

   task automatic receive_packets(input int count, input bit random_ready);
      int      got;
      int      rnd;
      packet_t exp_pkt;
      got = 0;
      while (got < count)
      begin
         @(posedge io_master_clk);
         rnd = $random(seed);
         core_ready_i <= random_ready ? rnd[0] : 1'b1;
         @(negedge io_master_clk);
         if (core_v_o && core_ready_i)
         begin
            if (expect_q.size() == 0)
               check_true("a packet arrived that was never sent", 1'b0);
            else
            begin
               exp_pkt = expect_q.pop_front();
               check_value($sformatf("packet %0d", got), exp_pkt, core_data_o);
            end
            got++;
            delivered_cnt++;
         end
      end
      @(posedge io_master_clk);
      core_ready_i <= 1'b0;
   endtask

   // a dead link must refuse everything the core offers
   task automatic run_dead(input int base);
      @(posedge io_master_clk);
      core_v_i     <= 1'b1;
      core_data_i  <= golden_mem[base];
      core_ready_i <= 1'b1;
      repeat (dead_watch_lp)
      begin
         @(negedge io_master_clk);
         check_true("core_yumi_o rose on a dead link", core_yumi_o === 1'b0);
         check_true("core_v_o rose on a dead link", core_v_o === 1'b0);
         check_true("link_up_o rose on a dead link", link_up_o === 1'b0);
      end
      @(posedge io_master_clk);
      core_v_i     <= 1'b0;
      core_ready_i <= 1'b0;
   endtask

   // ****************************************
   // main sequence
   // ****************************************

   initial
   begin
      int         num_rec;
      int         p;
      int         kind;
      int         count;
      int         base;
      int         errs_before;
      int         tests_run;
      int         tests_ok;
      lane_mask_t exp_mask;
      reset_i      = 1'b1;
      core_v_i     = 1'b0;
      core_data_i  = '0;
      core_ready_i = 1'b0;
      fault_mask   = '0;
      tests_run    = 0;
      tests_ok     = 0;
      $readmemh("sim/link_golden.txt", golden_mem);
      num_rec = int'(golden_mem[0]);

      // budget per record covers reset and training twice over plus 64 cycles per packet
      p = 1;
      for (int r = 0; r < num_rec; r++)
      begin
         count = int'(golden_mem[p + 3]);
         cycle_limit += reset_cycles_lp + 2 * `LINK_CALIB_CYCLES + 64 * count;
         p += 4 + count;
      end
      if (num_rec <= 0 || p > golden_depth_lp)
      begin
         $display("golden file is missing, empty or longer than %0d words", golden_depth_lp);
         error_cnt++;
         num_rec = 0;
      end

      p = 1;
      for (int r = 0; r < num_rec; r++)
      begin
         kind        = int'(golden_mem[p]);
         exp_mask    = lane_mask_t'(golden_mem[p + 2]);
         count       = int'(golden_mem[p + 3]);
         base        = p + 4;
         test_name   = $sformatf("rec%0d_%s", r, kind_name(kind));
         errs_before = error_cnt;
         apply_reset(lane_mask_t'(golden_mem[p + 1]));
         wait_link();
         check_value("active_mask_o", 64'(exp_mask), 64'(active_mask_o));
         if (kind == 2)
         begin
            check_true("link_dead_o did not rise with every lane faulted", link_dead_o);
            run_dead(base);
         end
         else
         begin
            check_true("link_up_o did not rise", link_up_o && !link_dead_o);
            fork
               send_packets(base, count);
               receive_packets(count, kind == 1);
            join
            @(negedge io_master_clk);
            check_true("core_v_o still high after the last expected packet", !core_v_o);
            check_true("link_dead_o rose on a working link", !link_dead_o);
         end
         tests_run++;
         if (error_cnt == errs_before)
         begin
            tests_ok++;
            $display("test %s: ok, %0d packets", test_name, count);
         end
         else
            $display("test %s: failed with %0d errors", test_name, error_cnt - errs_before);
         p = base + count;
      end

      $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
               tests_run, tests_ok, tests_run - tests_ok, error_cnt);
      if (error_cnt == 0 && tests_run > 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: sim/link_golden.txt
// word 0: record count; record: kind fault_mask expected_mask packet_count, then packets
// kind 0 ready high, 1 ready random, 2 dead link; fault bit n breaks lane n
5
// all lanes, core always ready
0 0 f 4
0123456789abcdef
fedcba9876543210
a5a55a5a00ff00ff
8000000000000001
// all lanes, random back-pressure
1 0 f 6
1122334455667788
99aabbccddeeff00
deadbeefcafef00d
0000000000000000
ffffffffffffffff
5a5aa5a5ff00ff00
// lane 1 broken, three lanes left
1 2 d 3
13579bdf2468ace0
0f1e2d3c4b5a6978
7766554433221100
// lanes 0 and 3 broken, two lanes left
0 9 6 3
c3c33c3c96966969
0102040810204080
fe01fd02fc03fb04
// every lane broken
2 f 0 2
abcdef0123456789
1234567887654321

// File: verilog.f
+incdir+design
design/link_data_pkg.sv
design/link_ctrl_pkg.sv
design/link_ctrl.sv
design/link_tx_packer.sv
design/link_rx_assembler.sv
design/comm_link_top.sv
sim/tb_comm_link.sv

// File: Makefile
# Verilator build and run of the link testbench

VERILATOR ?= verilator
TOP       ?= tb_comm_link
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= === FAIL ===
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
